// ==== all.f ====
common/datamem_pkg.sv
design/datamem_arbiter.sv
design/datamem_check.sv
memory/datamem_array.sv
design/datamem_response.sv
design/datamem_top.sv
verification/datamem_tb.sv

// ==== common/datamem_pkg.sv ====
package datamem_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    // Bytes in one CPU or accelerator word
    localparam int WORD_BYTES = 4;

    // Bytes in one accelerator line read
    localparam int LINE_BYTES = 64;

    // Default address width, 64 KiB of bytes
    localparam int ADDR_W_DEFAULT = 16;

    ////////////////////////////////////////////////////////////
    // Request tags
    ////////////////////////////////////////////////////////////

    // Requester that owns a transfer
    // Rides along with the request through every stage
    typedef enum logic {
        PORT_CPU = 1'b0,
        PORT_ACC = 1'b1
    } port_e;

    // Access kind, picked by the arbiter from we and the port
    // Accelerator reads are always whole lines
    typedef enum logic [1:0] {
        KIND_WRITE     = 2'd0,
        KIND_READ_WORD = 2'd1,
        KIND_READ_LINE = 2'd2
    } kind_e;

endpackage

// ==== design/datamem_arbiter.sv ====
module datamem_arbiter #(
    parameter int ADDR_W = datamem_pkg::ADDR_W_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // CPU Wishbone request side
    input  logic                                  cpu_cyc,
    input  logic                                  cpu_stb,
    input  logic                                  cpu_we,
    input  logic [ADDR_W-1:0]                     cpu_adr,
    input  logic [datamem_pkg::WORD_BYTES*8-1:0]  cpu_dat_w,
    // Accelerator Wishbone request side
    input  logic                                  acc_cyc,
    input  logic                                  acc_stb,
    input  logic                                  acc_we,
    input  logic [ADDR_W-1:0]                     acc_adr,
    input  logic [datamem_pkg::WORD_BYTES*8-1:0]  acc_dat_w,
    // Release pulses from the response stage
    input  logic                                  free_cpu,
    input  logic                                  free_acc,
    // Stage 1 output register
    output logic                                  s1_valid,
    output datamem_pkg::port_e                    s1_port,
    output datamem_pkg::kind_e                    s1_kind,
    output logic [ADDR_W-1:0]                     s1_adr,
    output logic [datamem_pkg::WORD_BYTES*8-1:0]  s1_dat_w
);
    import datamem_pkg::*;

    // One request in flight per port
    logic cpu_busy;
    logic acc_busy;
    logic grant_cpu;
    logic grant_acc;

    // CPU wins a tie, accelerator follows next edge
    // Busy alone blocks, so the stb still held in the ack cycle is not taken again
    assign grant_cpu = cpu_cyc && cpu_stb && !cpu_busy;
    assign grant_acc = acc_cyc && acc_stb && !acc_busy && !grant_cpu;

    ////////////////////////////////////////////////////////////
    // In-flight tracking
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_busy <= 1'b0;
            acc_busy <= 1'b0;
        end else begin
            // Grant and free never meet on one port
            if (grant_cpu) cpu_busy <= 1'b1;
            else if (free_cpu) cpu_busy <= 1'b0;
            if (grant_acc) acc_busy <= 1'b1;
            else if (free_acc) acc_busy <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 1 register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) s1_valid <= 1'b0;
        else s1_valid <= grant_cpu || grant_acc;
    end

    // Request fields, only meaningful with s1_valid
    always_ff @(posedge clk) begin
        if (grant_cpu) begin
            s1_port  <= PORT_CPU;
            s1_kind  <= cpu_we ? KIND_WRITE : KIND_READ_WORD;
            s1_adr   <= cpu_adr;
            s1_dat_w <= cpu_dat_w;
        end else if (grant_acc) begin
            s1_port  <= PORT_ACC;
            s1_kind  <= acc_we ? KIND_WRITE : KIND_READ_LINE;
            s1_adr   <= acc_adr;
            s1_dat_w <= acc_dat_w;
        end
    end

    // Never two grants in one cycle
    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(grant_cpu && grant_acc));

endmodule

// ==== design/datamem_check.sv ====
module datamem_check #(
    parameter int ADDR_W = datamem_pkg::ADDR_W_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // From the arbiter
    input  logic                                  s1_valid,
    input  datamem_pkg::port_e                    s1_port,
    input  datamem_pkg::kind_e                    s1_kind,
    input  logic [ADDR_W-1:0]                     s1_adr,
    input  logic [datamem_pkg::WORD_BYTES*8-1:0]  s1_dat_w,
    // To the array
    output logic                                  s2_valid,
    output datamem_pkg::port_e                    s2_port,
    output datamem_pkg::kind_e                    s2_kind,
    output logic [ADDR_W-1:0]                     s2_adr,
    output logic [datamem_pkg::WORD_BYTES*8-1:0]  s2_dat_w,
    output logic                                  s2_bad
);
    import datamem_pkg::*;

    // Last touched byte, one extra bit to catch the wrap
    logic [ADDR_W:0] last_byte;
    logic [ADDR_W:0] span;

    // Line reads cover 64 bytes, everything else 4
    assign span = (s1_kind == KIND_READ_LINE) ? (ADDR_W+1)'(LINE_BYTES - 1)
                                              : (ADDR_W+1)'(WORD_BYTES - 1);
    assign last_byte = {1'b0, s1_adr} + span;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) s2_valid <= 1'b0;
        else s2_valid <= s1_valid;
    end

    // Carry out means the access runs past the top of memory
    always_ff @(posedge clk) begin
        s2_port  <= s1_port;
        s2_kind  <= s1_kind;
        s2_adr   <= s1_adr;
        s2_dat_w <= s1_dat_w;
        s2_bad   <= last_byte[ADDR_W];
    end

    // Line reads only come from the accelerator side of the arbiter
    a_line_from_acc: assert property (@(posedge clk) disable iff (!rst_n)
        (s1_valid && s1_kind == KIND_READ_LINE) |-> (s1_port == PORT_ACC));

endmodule

// ==== design/datamem_response.sv ====
module datamem_response (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // From the array
    input  logic                                  s3_valid,
    input  datamem_pkg::port_e                    s3_port,
    input  logic                                  s3_bad,
    input  logic [datamem_pkg::LINE_BYTES*8-1:0]  s3_rd_line,
    // CPU Wishbone response side
    output logic [datamem_pkg::WORD_BYTES*8-1:0]  cpu_dat_r,
    output logic                                  cpu_ack,
    output logic                                  cpu_err,
    // Accelerator Wishbone response side
    output logic [datamem_pkg::LINE_BYTES*8-1:0]  acc_dat_r,
    output logic                                  acc_ack,
    output logic                                  acc_err,
    // Slot release back to the arbiter
    output logic                                  free_cpu,
    output logic                                  free_acc
);
    import datamem_pkg::*;

    // Which port the finishing request belongs to
    logic to_cpu;
    logic to_acc;

    assign to_cpu = s3_valid && (s3_port == PORT_CPU);
    assign to_acc = s3_valid && (s3_port == PORT_ACC);

    ////////////////////////////////////////////////////////////
    // Wishbone termination
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_ack   <= 1'b0;
            cpu_err   <= 1'b0;
            acc_ack   <= 1'b0;
            acc_err   <= 1'b0;
            cpu_dat_r <= '0;
            acc_dat_r <= '0;
        end else begin
            // Exactly one of ack or err, for one cycle
            cpu_ack <= to_cpu && !s3_bad;
            cpu_err <= to_cpu && s3_bad;
            acc_ack <= to_acc && !s3_bad;
            acc_err <= to_acc && s3_bad;
            // Read data held until that port's next response
            // CPU takes the low word only
            if (to_cpu) cpu_dat_r <= s3_bad ? '0 : s3_rd_line[WORD_BYTES*8-1:0];
            if (to_acc) acc_dat_r <= s3_bad ? '0 : s3_rd_line;
        end
    end

    // Slot frees in the same cycle as the termination
    assign free_cpu = cpu_ack || cpu_err;
    assign free_acc = acc_ack || acc_err;

    // One-cycle termination, never both at once
    a_cpu_term: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_ack || cpu_err) |-> !(cpu_ack && cpu_err) ##1 !(cpu_ack || cpu_err));
    a_acc_term: assert property (@(posedge clk) disable iff (!rst_n)
        (acc_ack || acc_err) |-> !(acc_ack && acc_err) ##1 !(acc_ack || acc_err));

endmodule

// ==== design/datamem_top.sv ====
module datamem_top #(
    parameter int ADDR_W = datamem_pkg::ADDR_W_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // CPU Wishbone slave
    input  logic                                  cpu_cyc,
    input  logic                                  cpu_stb,
    input  logic                                  cpu_we,
    input  logic [ADDR_W-1:0]                     cpu_adr,
    input  logic [datamem_pkg::WORD_BYTES*8-1:0]  cpu_dat_w,
    output logic [datamem_pkg::WORD_BYTES*8-1:0]  cpu_dat_r,
    output logic                                  cpu_ack,
    output logic                                  cpu_err,
    // Accelerator Wishbone slave
    input  logic                                  acc_cyc,
    input  logic                                  acc_stb,
    input  logic                                  acc_we,
    input  logic [ADDR_W-1:0]                     acc_adr,
    input  logic [datamem_pkg::WORD_BYTES*8-1:0]  acc_dat_w,
    output logic [datamem_pkg::LINE_BYTES*8-1:0]  acc_dat_r,
    output logic                                  acc_ack,
    output logic                                  acc_err
);
    import datamem_pkg::*;

    // Stage 1 to 2
    logic                      s1_valid;
    port_e                     s1_port;
    kind_e                     s1_kind;
    logic [ADDR_W-1:0]         s1_adr;
    logic [WORD_BYTES*8-1:0]   s1_dat_w;
    // Stage 2 to 3
    logic                      s2_valid;
    port_e                     s2_port;
    kind_e                     s2_kind;
    logic [ADDR_W-1:0]         s2_adr;
    logic [WORD_BYTES*8-1:0]   s2_dat_w;
    logic                      s2_bad;
    // Stage 3 to 4
    logic                      s3_valid;
    port_e                     s3_port;
    logic                      s3_bad;
    logic [LINE_BYTES*8-1:0]   s3_rd_line;
    // Release path back to stage 1
    logic                      free_cpu;
    logic                      free_acc;

    ////////////////////////////////////////////////////////////
    // Four-stage pipeline
    ////////////////////////////////////////////////////////////

    datamem_arbiter #(.ADDR_W(ADDR_W)) i_arbiter (
        .clk, .rst_n,
        .cpu_cyc, .cpu_stb, .cpu_we, .cpu_adr, .cpu_dat_w,
        .acc_cyc, .acc_stb, .acc_we, .acc_adr, .acc_dat_w,
        .free_cpu, .free_acc,
        .s1_valid, .s1_port, .s1_kind, .s1_adr, .s1_dat_w
    );

    datamem_check #(.ADDR_W(ADDR_W)) i_check (
        .clk, .rst_n,
        .s1_valid, .s1_port, .s1_kind, .s1_adr, .s1_dat_w,
        .s2_valid, .s2_port, .s2_kind, .s2_adr, .s2_dat_w, .s2_bad
    );

    datamem_array #(.ADDR_W(ADDR_W)) i_array (
        .clk, .rst_n,
        .s2_valid, .s2_port, .s2_kind, .s2_adr, .s2_dat_w, .s2_bad,
        .s3_valid, .s3_port, .s3_bad, .s3_rd_line
    );

    datamem_response i_response (
        .clk, .rst_n,
        .s3_valid, .s3_port, .s3_bad, .s3_rd_line,
        .cpu_dat_r, .cpu_ack, .cpu_err,
        .acc_dat_r, .acc_ack, .acc_err,
        .free_cpu, .free_acc
    );

endmodule

// ==== memory/datamem_array.sv ====
module datamem_array #(
    parameter int ADDR_W = datamem_pkg::ADDR_W_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // From the range check
    input  logic                                  s2_valid,
    input  datamem_pkg::port_e                    s2_port,
    input  datamem_pkg::kind_e                    s2_kind,
    input  logic [ADDR_W-1:0]                     s2_adr,
    input  logic [datamem_pkg::WORD_BYTES*8-1:0]  s2_dat_w,
    input  logic                                  s2_bad,
    // To the response stage
    output logic                                  s3_valid,
    output datamem_pkg::port_e                    s3_port,
    output logic                                  s3_bad,
    output logic [datamem_pkg::LINE_BYTES*8-1:0]  s3_rd_line
);
    import datamem_pkg::*;

    localparam int MEM_BYTES = 2 ** ADDR_W;

    ////////////////////////////////////////////////////////////
    // Byte storage
    ////////////////////////////////////////////////////////////

    // Contents are not cleared by reset
    logic [7:0] mem [MEM_BYTES];

    logic wr_en;
    logic rd_en;

    // Range check already killed anything that would wrap
    assign wr_en = s2_valid && !s2_bad && (s2_kind == KIND_WRITE);
    assign rd_en = s2_valid && !s2_bad && (s2_kind != KIND_WRITE);

    // Little endian, lowest data byte lands at the address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                mem[s2_adr + ADDR_W'(i)] <= s2_dat_w[8*i +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read path
    ////////////////////////////////////////////////////////////

    // Word read fills the low 4 bytes, the rest stays zero
    // Writes and bad reads return an all-zero line
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (rd_en && (s2_kind == KIND_READ_LINE || i < WORD_BYTES)) begin
                    s3_rd_line[8*i +: 8] <= mem[s2_adr + ADDR_W'(i)];
                end else begin
                    s3_rd_line[8*i +: 8] <= 8'h00;
                end
            end
        end
    end

    // Stage 3 control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) s3_valid <= 1'b0;
        else s3_valid <= s2_valid;
    end

    // Tag and error flag follow the data
    always_ff @(posedge clk) begin
        s3_port <= s2_port;
        s3_bad  <= s2_bad;
    end

    // Out-of-range write leaves the byte at its address untouched
    a_bad_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (s2_valid && s2_bad && s2_kind == KIND_WRITE)
        |=> (mem[$past(s2_adr)] === $past(mem[s2_adr])));

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the datamem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f all.f \
    --top-module datamem_tb \
    -o datamem_sim

./obj_dir/datamem_sim > sim.log
cat sim.log

# Verdict comes from the simulation log
if grep -q "Test FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation passed"
exit 0

// ==== verification/datamem_tb.sv ====
module datamem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import datamem_pkg::*;

    localparam int ADDR_W    = 16;
    localparam int MEM_BYTES = 1 << ADDR_W;
    localparam int T_CLK     = 40;
    // Transfers issued by the sequence below
    localparam int N_TRANS   = 78;

    logic                    clk;
    logic                    rst_n;
    logic                    cpu_cyc;
    logic                    cpu_stb;
    logic                    cpu_we;
    logic [ADDR_W-1:0]       cpu_adr;
    logic [WORD_BYTES*8-1:0] cpu_dat_w;
    logic [WORD_BYTES*8-1:0] cpu_dat_r;
    logic                    cpu_ack;
    logic                    cpu_err;
    logic                    acc_cyc;
    logic                    acc_stb;
    logic                    acc_we;
    logic [ADDR_W-1:0]       acc_adr;
    logic [WORD_BYTES*8-1:0] acc_dat_w;
    logic [LINE_BYTES*8-1:0] acc_dat_r;
    logic                    acc_ack;
    logic                    acc_err;

    // Expected response of the transfer in progress on each port
    logic                    cpu_chk_rd;
    logic                    cpu_exp_err;
    logic [WORD_BYTES*8-1:0] cpu_exp_dat;
    logic                    acc_chk_rd;
    logic                    acc_exp_err;
    logic [LINE_BYTES*8-1:0] acc_exp_line;

    // Acceptance model, one transfer per port, CPU first on a tie
    logic cpu_inflight;
    logic acc_inflight;
    logic cpu_go;
    logic acc_go;
    logic cpu_term;
    logic acc_term;

    logic [7:0]  model [MEM_BYTES];
    logic [15:0] lfsr_state;
    int          value_errors;
    int          resp_errors;
    int          timing_errors;

    datamem_top #(.ADDR_W(ADDR_W)) i_datamem_top (
        .clk, .rst_n,
        .cpu_cyc, .cpu_stb, .cpu_we, .cpu_adr, .cpu_dat_w,
        .cpu_dat_r, .cpu_ack, .cpu_err,
        .acc_cyc, .acc_stb, .acc_we, .acc_adr, .acc_dat_w,
        .acc_dat_r, .acc_ack, .acc_err
    );

    initial begin
        clk = 1'b0;
        forever #(T_CLK / 2) clk = ~clk;
    end

    assign cpu_go   = cpu_cyc && cpu_stb && !cpu_inflight;
    assign acc_go   = acc_cyc && acc_stb && !acc_inflight && !cpu_go;
    assign cpu_term = cpu_ack || cpu_err;
    assign acc_term = acc_ack || acc_err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_inflight <= 1'b0;
            acc_inflight <= 1'b0;
        end else begin
            if (cpu_go) cpu_inflight <= 1'b1;
            else if (cpu_term) cpu_inflight <= 1'b0;
            if (acc_go) acc_inflight <= 1'b1;
            else if (acc_term) acc_inflight <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Last byte past the top of memory
    function automatic logic out_of_range(input int adr, input int len);
        return (adr + len) > MEM_BYTES;
    endfunction

    task automatic cpu_access(input logic we, input logic [ADDR_W-1:0] adr,
                              input logic [WORD_BYTES*8-1:0] dat);
        logic bad;
        int   i;
        bad = out_of_range(int'(adr), WORD_BYTES);
        @(negedge clk);
        cpu_exp_err = bad;
        cpu_chk_rd  = !we;
        cpu_exp_dat = '0;
        // Little endian, byte at the address is the low byte
        for (i = 0; i < WORD_BYTES; i++) begin
            if (we && !bad) model[int'(adr) + i] = dat[8*i +: 8];
            if (!we && !bad) cpu_exp_dat[8*i +: 8] = model[int'(adr) + i];
        end
        cpu_we    = we;
        cpu_adr   = adr;
        cpu_dat_w = dat;
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        do @(negedge clk); while (!(cpu_ack || cpu_err));
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;
    endtask

    task automatic acc_access(input logic we, input logic [ADDR_W-1:0] adr,
                              input logic [WORD_BYTES*8-1:0] dat);
        logic bad;
        int   i;
        // Accelerator reads are whole lines
        bad = out_of_range(int'(adr), we ? WORD_BYTES : LINE_BYTES);
        @(negedge clk);
        acc_exp_err  = bad;
        acc_chk_rd   = !we;
        acc_exp_line = '0;
        for (i = 0; i < WORD_BYTES; i++) begin
            if (we && !bad) model[int'(adr) + i] = dat[8*i +: 8];
        end
        for (i = 0; i < LINE_BYTES; i++) begin
            if (!we && !bad) acc_exp_line[8*i +: 8] = model[int'(adr) + i];
        end
        acc_we    = we;
        acc_adr   = adr;
        acc_dat_w = dat;
        acc_cyc   = 1'b1;
        acc_stb   = 1'b1;
        do @(negedge clk); while (!(acc_ack || acc_err));
        acc_cyc = 1'b0;
        acc_stb = 1'b0;
        acc_we  = 1'b0;
    endtask

    task automatic cpu_write(input logic [ADDR_W-1:0] adr, input logic [31:0] dat);
        cpu_access(1'b1, adr, dat);
    endtask

    task automatic cpu_read(input logic [ADDR_W-1:0] adr);
        cpu_access(1'b0, adr, '0);
    endtask

    task automatic acc_write(input logic [ADDR_W-1:0] adr, input logic [31:0] dat);
        acc_access(1'b1, adr, dat);
    endtask

    task automatic acc_read(input logic [ADDR_W-1:0] adr);
        acc_access(1'b0, adr, '0);
    endtask

    ////////////////////////////////////////////////////////////
    // Response checks
    ////////////////////////////////////////////////////////////

    // Answer in the fifth cycle after acceptance, never earlier
    a_cpu_latency: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_go |-> ##4 cpu_term)
        else begin
            timing_errors++;
            $display("CPU request was not answered four cycles after acceptance");
        end
    a_cpu_early: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_term |-> $past(cpu_go, 4))
        else begin
            timing_errors++;
            $display("CPU answer came at the wrong time after acceptance");
        end
    a_acc_latency: assert property (@(posedge clk) disable iff (!rst_n)
        acc_go |-> ##4 acc_term)
        else begin
            timing_errors++;
            $display("Accelerator request was not answered four cycles after acceptance");
        end
    a_acc_early: assert property (@(posedge clk) disable iff (!rst_n)
        acc_term |-> $past(acc_go, 4))
        else begin
            timing_errors++;
            $display("Accelerator answer came at the wrong time after acceptance");
        end
    // Same-cycle requests, accelerator one cycle behind
    a_tie_order: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_go && acc_cyc && acc_stb && !acc_inflight)
        |-> ##4 (cpu_term && !acc_term) ##1 acc_term)
        else begin
            timing_errors++;
            $display("Accelerator answer did not follow the CPU answer by one cycle");
        end

    // Exactly one termination per request
    a_cpu_single: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_term |-> (cpu_inflight && !(cpu_ack && cpu_err)))
        else begin
            resp_errors++;
            $display("CPU port terminated with nothing in flight or with ack and err");
        end
    a_acc_single: assert property (@(posedge clk) disable iff (!rst_n)
        acc_term |-> (acc_inflight && !(acc_ack && acc_err)))
        else begin
            resp_errors++;
            $display("Accelerator port terminated with nothing in flight or with ack and err");
        end

    a_cpu_kind: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_term |-> (cpu_err == cpu_exp_err))
        else begin
            resp_errors++;
            $display("ERROR cpu_err expected %h actual %h", $sampled(cpu_exp_err),
                     $sampled(cpu_err));
        end
    a_acc_kind: assert property (@(posedge clk) disable iff (!rst_n)
        acc_term |-> (acc_err == acc_exp_err))
        else begin
            resp_errors++;
            $display("ERROR acc_err expected %h actual %h", $sampled(acc_exp_err),
                     $sampled(acc_err));
        end

    // Read data against the byte model
    a_cpu_data: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_ack && cpu_chk_rd) |-> (cpu_dat_r == cpu_exp_dat))
        else begin
            value_errors++;
            $display("ERROR cpu_dat_r expected %h actual %h", $sampled(cpu_exp_dat),
                     $sampled(cpu_dat_r));
        end
    a_acc_data: assert property (@(posedge clk) disable iff (!rst_n)
        (acc_ack && acc_chk_rd) |-> (acc_dat_r == acc_exp_line))
        else begin
            value_errors++;
            $display("ERROR acc_dat_r expected %h actual %h", $sampled(acc_exp_line),
                     $sampled(acc_dat_r));
        end
    // Zero data with err
    a_cpu_zero: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_err |-> (cpu_dat_r == '0))
        else begin
            value_errors++;
            $display("ERROR cpu_dat_r expected %h actual %h", 32'h0, $sampled(cpu_dat_r));
        end
    a_acc_zero: assert property (@(posedge clk) disable iff (!rst_n)
        acc_err |-> (acc_dat_r == '0))
        else begin
            value_errors++;
            $display("ERROR acc_dat_r expected %h actual %h", 512'h0, $sampled(acc_dat_r));
        end

    ////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [ADDR_W-1:0] adr;
        logic [ADDR_W-1:0] first_adr;
        logic [ADDR_W-1:0] line;
        logic [31:0]       dat;
        logic [31:0]       top_dat;
        int                n;
        int                off;
        rst_n = 1'b0;
        {cpu_cyc, cpu_stb, cpu_we, acc_cyc, acc_stb, acc_we} = '0;
        cpu_adr = '0;
        cpu_dat_w = '0;
        acc_adr = '0;
        acc_dat_w = '0;
        {cpu_chk_rd, cpu_exp_err, acc_chk_rd, acc_exp_err} = '0;
        cpu_exp_dat = '0;
        acc_exp_line = '0;
        lfsr_state = 16'd96;
        value_errors = 0;
        resp_errors = 0;
        timing_errors = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Unaligned CPU write then read back
        first_adr = ADDR_W'(rand_bits(15));
        for (n = 0; n < 8; n++) begin
            adr = (n == 0) ? first_adr : ADDR_W'(rand_bits(15));
            dat = rand_bits(32);
            cpu_write(adr, dat);
            cpu_read(adr);
        end

        // Fill a line from the accelerator, read it from both ports
        line = ADDR_W'(32'h8000 + (rand_bits(8) << 6));
        for (n = 0; n < 16; n++) acc_write(line + ADDR_W'(4 * n), rand_bits(32));
        acc_read(line);
        off = int'(rand_bits(6) % 61);
        cpu_read(line + ADDR_W'(off));

        // Top of memory, only 16'hFFFC may hold a word
        top_dat = rand_bits(32);
        cpu_write(16'hFFFC, top_dat);
        cpu_write(16'hFFFD, rand_bits(32));
        cpu_read(16'hFFFE);
        cpu_write(16'hFFFF, rand_bits(32));
        acc_read(16'hFFC1);
        acc_read(16'hFFFF);
        acc_write(16'hFFFE, rand_bits(32));
        cpu_read(16'hFFFC);

        // Both ports in the same cycle
        fork
            cpu_read(first_adr);
            acc_write(16'hC000, rand_bits(32));
        join

        // Back-to-back traffic, disjoint regions per port
        fork
            begin
                for (int k = 0; k < 6; k++) begin
                    adr = ADDR_W'(32'h4000 + rand_bits(12));
                    dat = rand_bits(32);
                    cpu_write(adr, dat);
                    cpu_read(adr);
                end
            end
            begin
                for (int k = 0; k < 16; k++) acc_write(16'hC000 + ADDR_W'(4 * k), rand_bits(32));
                acc_read(16'hC000);
                for (int k = 0; k < 4; k++) acc_write(16'hC010 + ADDR_W'(4 * k), rand_bits(32));
                acc_read(16'hC000);
            end
        join

        // Let the last termination checks fire
        repeat (6) @(negedge clk);
        $display("Errors: value %0d, response %0d, timing %0d",
                 value_errors, resp_errors, timing_errors);
        if (value_errors + resp_errors + timing_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // About 8 cycles per transfer plus reset
    initial begin
        #((N_TRANS * 8 + 20) * T_CLK);
        $display("Watchdog expired, the run hung waiting for ack or err");
        $display("Test FAILED");
        $finish;
    end

endmodule
